//--- design/pmp_pkg.sv
package pmp_pkg;

    localparam int PMP_ENTRIES = 8;
    localparam int PMA_ENTRIES = 4;
    localparam int PMP_IDX_W   = $clog2(PMP_ENTRIES);
    localparam int PMA_IDX_W   = $clog2(PMA_ENTRIES);

    // word address, byte address bits 31 to 2
    localparam int ADDR_W   = 30;
    localparam int WB_ADR_W = 5;

    // register map, in words
    localparam logic [WB_ADR_W-1:0] ADR_PMPADDR = 5'd0;
    localparam logic [WB_ADR_W-1:0] ADR_PMPCFG0 = 5'd8;
    localparam logic [WB_ADR_W-1:0] ADR_PMPCFG1 = 5'd9;
    localparam logic [WB_ADR_W-1:0] ADR_PMAADDR = 5'd16;
    localparam logic [WB_ADR_W-1:0] ADR_PMACFG  = 5'd20;

    // address-matching modes
    localparam logic [1:0] A_OFF   = 2'd0;
    localparam logic [1:0] A_TOR   = 2'd1;
    localparam logic [1:0] A_NA4   = 2'd2;
    localparam logic [1:0] A_NAPOT = 2'd3;

    // no lock bit, so the top three bits are reserved
    typedef struct packed {
        logic [2:0] rsvd;
        logic [1:0] a;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_t;

    typedef struct packed {
        logic [1:0] a;
        logic       uc;
        logic [4:0] rsvd;
    } pma_cfg_t;

    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } acc_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        acc_t              acc;
    } check_req_t;

    // stage one result, with the pmp cfg copy that goes along with it
    typedef struct packed {
        check_req_t                       req;
        pmp_cfg_t [PMP_ENTRIES-1:0]       cfg;
        logic [PMP_ENTRIES-1:0]           pmp_hit;
        logic [PMA_ENTRIES-1:0]           pma_hit;
    } match_t;

    typedef struct packed {
        logic                 fault;
        logic                 uncached;
        logic [PMP_IDX_W-1:0] idx;
        logic                 found;
    } check_rsp_t;

endpackage

//--- design/pmp_csr_wb.sv
`timescale 1ns/1ns

module pmp_csr_wb (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          wb_cyc,
    input  logic                                          wb_stb,
    input  logic                                          wb_we,
    input  logic [pmp_pkg::WB_ADR_W-1:0]                  wb_adr,
    input  logic [31:0]                                   wb_dat_w,
    output logic [31:0]                                   wb_dat_r,
    output logic                                          wb_ack,
    output pmp_pkg::pmp_cfg_t [pmp_pkg::PMP_ENTRIES-1:0]  pmp_cfg,
    output logic [pmp_pkg::PMP_ENTRIES-1:0][pmp_pkg::ADDR_W-1:0] pmp_addr,
    output pmp_pkg::pma_cfg_t [pmp_pkg::PMA_ENTRIES-1:0]  pma_cfg,
    output logic [pmp_pkg::PMA_ENTRIES-1:0][pmp_pkg::ADDR_W-1:0] pma_addr
);

    logic                          req_seen;
    logic                          wr_en;
    logic                          sel_pmpaddr;
    logic                          sel_pmaaddr;
    logic [pmp_pkg::PMP_IDX_W-1:0] pmp_sel;
    logic [pmp_pkg::PMA_IDX_W-1:0] pma_sel;
    logic [31:0]                   rd_data;

    // new cycle only, a held stb is not acked twice
    assign req_seen = wb_cyc && wb_stb && !wb_ack;
    assign wr_en    = req_seen && wb_we;

    assign sel_pmpaddr = (wb_adr >= pmp_pkg::ADR_PMPADDR) &&
                         (wb_adr < pmp_pkg::ADR_PMPADDR + pmp_pkg::PMP_ENTRIES);
    assign sel_pmaaddr = (wb_adr >= pmp_pkg::ADR_PMAADDR) &&
                         (wb_adr < pmp_pkg::ADR_PMAADDR + pmp_pkg::PMA_ENTRIES);
    // both address banks start on aligned words
    assign pmp_sel = wb_adr[pmp_pkg::PMP_IDX_W-1:0];
    assign pma_sel = wb_adr[pmp_pkg::PMA_IDX_W-1:0];

    always_comb begin
        rd_data = '0;
        if (sel_pmpaddr) begin
            rd_data[pmp_pkg::ADDR_W-1:0] = pmp_addr[pmp_sel];
        end else if (sel_pmaaddr) begin
            rd_data[pmp_pkg::ADDR_W-1:0] = pma_addr[pma_sel];
        end else if (wb_adr == pmp_pkg::ADR_PMPCFG0) begin
            rd_data = pmp_cfg[3:0];
        end else if (wb_adr == pmp_pkg::ADR_PMPCFG1) begin
            rd_data = pmp_cfg[7:4];
        end else if (wb_adr == pmp_pkg::ADR_PMACFG) begin
            rd_data = pma_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            pmp_cfg  <= '0;
            pmp_addr <= '0;
            pma_cfg  <= '0;
            pma_addr <= '0;
        end else begin
            wb_ack <= req_seen;
            if (wr_en) begin
                if (sel_pmpaddr) begin
                    pmp_addr[pmp_sel] <= wb_dat_w[pmp_pkg::ADDR_W-1:0];
                end else if (sel_pmaaddr) begin
                    pma_addr[pma_sel] <= wb_dat_w[pmp_pkg::ADDR_W-1:0];
                end else if (wb_adr == pmp_pkg::ADR_PMPCFG0) begin
                    pmp_cfg[3:0] <= wb_dat_w;
                end else if (wb_adr == pmp_pkg::ADR_PMPCFG1) begin
                    pmp_cfg[7:4] <= wb_dat_w;
                end else if (wb_adr == pmp_pkg::ADR_PMACFG) begin
                    pma_cfg <= wb_dat_w;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_seen) begin
            wb_dat_r <= rd_data;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

//--- design/pmp_region_match.sv
`timescale 1ns/1ns

module pmp_region_match (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          req_valid,
    input  pmp_pkg::check_req_t                           req,
    input  pmp_pkg::pmp_cfg_t [pmp_pkg::PMP_ENTRIES-1:0]  pmp_cfg,
    input  logic [pmp_pkg::PMP_ENTRIES-1:0][pmp_pkg::ADDR_W-1:0] pmp_addr,
    input  pmp_pkg::pma_cfg_t [pmp_pkg::PMA_ENTRIES-1:0]  pma_cfg,
    input  logic [pmp_pkg::PMA_ENTRIES-1:0][pmp_pkg::ADDR_W-1:0] pma_addr,
    output logic                                          s1_valid,
    output pmp_pkg::match_t                               s1
);

    // don't-care bits of a napot region: the trailing ones and the zero above them
    function automatic logic [pmp_pkg::ADDR_W-1:0] napot_mask(
        input logic [pmp_pkg::ADDR_W-1:0] base
    );
        logic [pmp_pkg::ADDR_W-1:0] mask;
        logic                       run;
        int                         ones;
        run  = 1'b1;
        ones = 0;
        for (int b = 0; b < pmp_pkg::ADDR_W; b++) begin
            if (run && base[b]) begin
                ones = ones + 1;
            end else begin
                run = 1'b0;
            end
        end
        for (int b = 0; b < pmp_pkg::ADDR_W; b++) begin
            mask[b] = (b <= ones);
        end
        return mask;
    endfunction

    logic [pmp_pkg::PMP_ENTRIES-1:0] pmp_below;
    logic [pmp_pkg::PMP_ENTRIES-1:0] pmp_tor;
    logic [pmp_pkg::PMP_ENTRIES-1:0] pmp_na4;
    logic [pmp_pkg::PMP_ENTRIES-1:0] pmp_napot;
    logic [pmp_pkg::PMP_ENTRIES-1:0] pmp_hit;
    logic [pmp_pkg::PMA_ENTRIES-1:0] pma_below;
    logic [pmp_pkg::PMA_ENTRIES-1:0] pma_tor;
    logic [pmp_pkg::PMA_ENTRIES-1:0] pma_hit;

    for (genvar i = 0; i < pmp_pkg::PMP_ENTRIES; i++) begin : g_pmp
        logic [pmp_pkg::ADDR_W-1:0] mask;

        assign pmp_below[i] = req.addr < pmp_addr[i];
        // tor is [pmpaddr[i-1], pmpaddr[i]), entry 0 starts at zero
        if (i == 0) begin : g_first
            assign pmp_tor[i] = pmp_below[i];
        end else begin : g_rest
            assign pmp_tor[i] = pmp_below[i] & ~pmp_below[i-1];
        end

        assign pmp_na4[i]   = req.addr == pmp_addr[i];
        assign mask         = napot_mask(pmp_addr[i]);
        assign pmp_napot[i] = ((req.addr ^ pmp_addr[i]) & ~mask) == '0;

        always_comb begin
            case (pmp_cfg[i].a)
                pmp_pkg::A_TOR:   pmp_hit[i] = pmp_tor[i];
                pmp_pkg::A_NA4:   pmp_hit[i] = pmp_na4[i];
                pmp_pkg::A_NAPOT: pmp_hit[i] = pmp_napot[i];
                default:          pmp_hit[i] = 1'b0;
            endcase
        end
    end

    // only tor counts for pma, and only uncached entries matter downstream
    for (genvar i = 0; i < pmp_pkg::PMA_ENTRIES; i++) begin : g_pma
        assign pma_below[i] = req.addr < pma_addr[i];
        if (i == 0) begin : g_first
            assign pma_tor[i] = pma_below[i];
        end else begin : g_rest
            assign pma_tor[i] = pma_below[i] & ~pma_below[i-1];
        end
        assign pma_hit[i] = (pma_cfg[i].a == pmp_pkg::A_TOR) & pma_cfg[i].uc & pma_tor[i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1.req     <= req;
        s1.cfg     <= pmp_cfg;
        s1.pmp_hit <= pmp_hit;
        s1.pma_hit <= pma_hit;
    end

    a_idle_after_rst: assert property (@(posedge clk) rst |=> !s1_valid);

endmodule

//--- design/pmp_priority_check.sv
`timescale 1ns/1ns

module pmp_priority_check (
    input  logic                clk,
    input  logic                rst,
    input  logic                s1_valid,
    input  pmp_pkg::match_t     s1,
    output logic                rsp_valid,
    output pmp_pkg::check_rsp_t rsp
);

    logic                          found;
    logic [pmp_pkg::PMP_IDX_W-1:0] idx;
    pmp_pkg::pmp_cfg_t             sel_cfg;
    logic                          allowed;

    // walk down so the lowest hit index wins
    always_comb begin
        found = 1'b0;
        idx   = '0;
        for (int i = pmp_pkg::PMP_ENTRIES - 1; i >= 0; i--) begin
            if (s1.pmp_hit[i]) begin
                found = 1'b1;
                idx   = i[pmp_pkg::PMP_IDX_W-1:0];
            end
        end
    end

    assign sel_cfg = s1.cfg[idx];

    always_comb begin
        case (s1.req.acc)
            pmp_pkg::ACC_READ:  allowed = sel_cfg.r;
            pmp_pkg::ACC_WRITE: allowed = sel_cfg.w;
            pmp_pkg::ACC_EXEC:  allowed = sel_cfg.x;
            default:            allowed = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        // no matching entry means fault, supervisor and user modes only
        rsp.fault    <= !found || !allowed;
        rsp.uncached <= |s1.pma_hit;
        rsp.idx      <= idx;
        rsp.found    <= found;
    end

    a_miss_faults: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp.found |-> rsp.fault);

endmodule

//--- design/pmp_checker_top.sv
`timescale 1ns/1ns

module pmp_checker_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [pmp_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    input  logic                         req_valid,
    input  pmp_pkg::check_req_t          req,
    output logic                         rsp_valid,
    output pmp_pkg::check_rsp_t          rsp
);

    pmp_pkg::pmp_cfg_t [pmp_pkg::PMP_ENTRIES-1:0]            pmp_cfg;
    logic [pmp_pkg::PMP_ENTRIES-1:0][pmp_pkg::ADDR_W-1:0]    pmp_addr;
    pmp_pkg::pma_cfg_t [pmp_pkg::PMA_ENTRIES-1:0]            pma_cfg;
    logic [pmp_pkg::PMA_ENTRIES-1:0][pmp_pkg::ADDR_W-1:0]    pma_addr;
    logic                                                    s1_valid;
    pmp_pkg::match_t                                         s1;

    pmp_csr_wb u_csr (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .pmp_cfg(pmp_cfg), .pmp_addr(pmp_addr),
        .pma_cfg(pma_cfg), .pma_addr(pma_addr)
    );

    pmp_region_match u_match (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req(req),
        .pmp_cfg(pmp_cfg), .pmp_addr(pmp_addr),
        .pma_cfg(pma_cfg), .pma_addr(pma_addr),
        .s1_valid(s1_valid), .s1(s1)
    );

    pmp_priority_check u_check (
        .clk(clk), .rst(rst),
        .s1_valid(s1_valid), .s1(s1),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

endmodule

//--- tb/pmp_check_mon.sv
`timescale 1ns/1ns

module pmp_check_mon (
    input  logic                         clk,
    input  logic                         rst,
    input  int                           line_no,
    input  logic                         req_valid,
    input  pmp_pkg::check_req_t          req,
    input  logic                         exp_fault,
    input  logic                         exp_uc,
    input  logic                         rsp_valid,
    input  pmp_pkg::check_rsp_t          rsp,
    input  logic                         wb_we,
    input  logic [pmp_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    input  logic [31:0]                  wb_dat_r,
    input  logic                         wb_ack,
    input  logic [31:0]                  exp_rd,
    output int                           tests,
    output int                           errors,
    output int                           pending
);

    // one entry per check in flight, due is the cycle its response must show
    typedef struct packed {
        logic [31:0]                trace_line;
        logic [31:0]                due;
        logic [pmp_pkg::ADDR_W-1:0] addr;
        logic                       fault;
        logic                       uc;
    } expect_t;

    expect_t     inflight [$];
    expect_t     head;
    logic [31:0] cycle;
    logic        bad;

    always @(posedge clk) begin
        if (rst) begin
            tests  = 0;
            errors = 0;
            cycle  = 0;
        end else begin
            cycle++;
            if (inflight.size() > 0 && inflight[0].due < cycle) begin
                head = inflight.pop_front();
                tests++;
                errors++;
                $display("line %0d: no response for check at 0x%08h", head.trace_line,
                         {head.addr, 2'b00});
            end
            if (rsp_valid && inflight.size() == 0) begin
                errors++;
                $display("Error: response at cycle %0d with no check in flight", cycle);
            end else if (rsp_valid) begin
                head = inflight.pop_front();
                tests++;
                bad  = 1'b0;
                if (head.due != cycle) begin
                    $display("line %0d: response came at cycle %0d, due at cycle %0d",
                             head.trace_line, cycle, head.due);
                    bad = 1'b1;
                end
                if (rsp.fault !== head.fault) begin
                    $display("Mismatch line %0d: rsp.fault expected 0x%0h got 0x%0h",
                             head.trace_line, head.fault, rsp.fault);
                    bad = 1'b1;
                end
                // a granted access always comes from a matching entry
                if (!head.fault && rsp.found !== 1'b1) begin
                    $display("Mismatch line %0d: rsp.found expected 0x1 got 0x%0h",
                             head.trace_line, rsp.found);
                    bad = 1'b1;
                end
                if (rsp.uncached !== head.uc) begin
                    $display("Mismatch line %0d: rsp.uncached expected 0x%0h got 0x%0h",
                             head.trace_line, head.uc, rsp.uncached);
                    bad = 1'b1;
                end
                if (bad) begin
                    errors++;
                end
                $display("line %0d: check 0x%08h %s", head.trace_line, {head.addr, 2'b00},
                         bad ? "FAIL" : "ok");
            end
            if (req_valid) begin
                inflight.push_back('{trace_line: line_no, due: cycle + 2, addr: req.addr,
                                     fault: exp_fault, uc: exp_uc});
            end
            // read data comes back together with ack
            if (wb_ack) begin
                tests++;
                if (wb_we) begin
                    $display("line %0d: write 0x%08h to reg 0x%02h ok",
                             line_no, wb_dat_w, wb_adr);
                end else if (wb_dat_r !== exp_rd) begin
                    errors++;
                    $display("Mismatch line %0d: wb_dat_r expected 0x%08h got 0x%08h",
                             line_no, exp_rd, wb_dat_r);
                end else begin
                    $display("line %0d: read reg 0x%02h = 0x%08h ok",
                             line_no, wb_adr, wb_dat_r);
                end
            end
        end
        pending = inflight.size();
    end

endmodule

//--- tb/pmp_tb.sv
`timescale 1ns/1ns

module pmp_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int CYCLES_PER_OP = 200;
    localparam int ACK_LIMIT     = 20;

    logic                         clk;
    logic                         rst;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [pmp_pkg::WB_ADR_W-1:0] wb_adr;
    logic [31:0]                  wb_dat_w;
    logic [31:0]                  wb_dat_r;
    logic                         wb_ack;
    logic                         req_valid;
    pmp_pkg::check_req_t          req;
    logic                         rsp_valid;
    pmp_pkg::check_rsp_t          rsp;
    logic                         exp_fault;
    logic                         exp_uc;
    logic [31:0]                  exp_rd;
    int                           line_no;
    int                           mon_tests;
    int                           mon_errors;
    int                           pending;
    int                           drv_errors;
    int                           n_ops;
    logic                         trace_loaded;
    byte                          op_kind [$];
    int                           op_line [$];
    logic [31:0]                  op_a [$];
    logic [31:0]                  op_b [$];
    logic [31:0]                  op_c [$];
    logic [31:0]                  op_d [$];

    pmp_checker_top UUT (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .req_valid(req_valid), .req(req),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

    pmp_check_mon u_mon (
        .clk(clk), .rst(rst), .line_no(line_no),
        .req_valid(req_valid), .req(req), .exp_fault(exp_fault), .exp_uc(exp_uc),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .exp_rd(exp_rd),
        .tests(mon_tests), .errors(mon_errors), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // limit grows with the number of trace operations
    initial begin
        wait (trace_loaded);
        repeat (n_ops * CYCLES_PER_OP + 20) @(posedge clk);
        $display("Timeout: trace not finished after %0d cycles", n_ops * CYCLES_PER_OP + 20);
        $display("Simulation failed");
        $finish;
    end

    task automatic load_trace();
        int          fd;
        int          n;
        int          num;
        string       text;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        num = 0;
        fd  = $fopen("tb/pmp_trace.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open tb/pmp_trace.txt");
            drv_errors++;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n    = $fgets(text, fd);
            num++;
            if (n > 1 && text.getc(0) != "#") begin
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                n = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h", a, b, c, d);
                op_kind.push_back(text.getc(0));
                op_line.push_back(num);
                op_a.push_back(a);
                op_b.push_back(b);
                op_c.push_back(c);
                op_d.push_back(d);
            end
        end
        $fclose(fd);
    endtask

    // cyc first, stb after a random wait, both dropped once ack is seen
    task automatic wb_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] data, input int line);
        int stb_delay;
        int wait_cycles;
        stb_delay = $urandom % 3;
        @(negedge clk);
        req_valid = 1'b0;
        line_no   = line;
        wb_cyc    = 1'b1;
        wb_we     = we;
        wb_adr    = adr[pmp_pkg::WB_ADR_W-1:0];
        wb_dat_w  = we ? data : 32'h0;
        exp_rd    = data;
        repeat (stb_delay) @(negedge clk);
        wb_stb      = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!wb_ack && wait_cycles < ACK_LIMIT);
        if (!wb_ack) begin
            $display("line %0d: no wb_ack within %0d cycles", line, ACK_LIMIT);
            drv_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic issue_check(input logic [31:0] addr, input logic [31:0] acc,
                               input logic fault, input logic uc,
                               input logic back_to_back, input int line);
        int gap;
        gap = back_to_back ? 0 : 1 + $urandom % 3;
        repeat (gap) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
        @(negedge clk);
        line_no   = line;
        req_valid = 1'b1;
        req.addr  = addr[31:2];
        req.acc   = pmp_pkg::acc_t'(acc[1:0]);
        exp_fault = fault;
        exp_uc    = uc;
    endtask

    initial begin
        void'($urandom(32'h60a2_e132));
        trace_loaded = 1'b0;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        req_valid    = 1'b0;
        req          = '0;
        exp_fault    = 1'b0;
        exp_uc       = 1'b0;
        exp_rd       = '0;
        line_no      = 0;
        drv_errors   = 0;
        load_trace();
        n_ops        = op_kind.size();
        trace_loaded = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            case (op_kind[i])
                "W": wb_access(1'b1, op_a[i], op_b[i], op_line[i]);
                "R": wb_access(1'b0, op_a[i], op_b[i], op_line[i]);
                "C": issue_check(op_a[i], op_b[i], op_c[i][0], op_d[i][0], 1'b0, op_line[i]);
                "B": issue_check(op_a[i], op_b[i], op_c[i][0], op_d[i][0], 1'b1, op_line[i]);
                default: begin
                    $display("line %0d: unknown operation in trace", op_line[i]);
                    drv_errors++;
                end
            endcase
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait (pending == 0);
        repeat (2) @(negedge clk);
        $display("Summary: %0d tests, %0d errors", mon_tests + drv_errors,
                 mon_errors + drv_errors);
        if (mon_errors + drv_errors == 0 && n_ops > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb/pmp_trace.txt
# W adr data | R adr expect | C/B byte_addr acc(0 r 1 w 2 x) fault uc, B is back to back
C 00001000 0 1 0
C 80000000 2 1 0
W 00 00000400
R 00 00000400
R 1f 00000000
W 01 00000800
W 02 000011ff
W 03 000017ff
W 08 1b19130d
R 08 1b19130d
W 10 00000400
W 11 00001100
W 14 00006040
C 00000ffc 0 0 0
C 00000ffc 1 1 0
C 00001000 0 1 1
C 00002000 1 0 1
C 00002004 0 1 1
C 00004800 0 0 0
C 00004800 1 1 0
B 00005000 1 0 0
B 00008000 0 1 0
B 00000800 2 0 0

//--- pmp_sim.f
design/pmp_pkg.sv
design/pmp_csr_wb.sv
design/pmp_region_match.sv
design/pmp_priority_check.sv
design/pmp_checker_top.sv
tb/pmp_check_mon.sv
tb/pmp_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module pmp_tb -f pmp_sim.f -o pmp_sim &&
./obj_dir/pmp_sim > sim.log 2>&1 ||
echo "build or simulation run did not complete"
grep -q "Simulation completed successfully" sim.log 2>/dev/null || { echo "FAIL"; exit 1; }
echo "PASS"
